//--- hdl/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Data path and address width
`define MIPS_XLEN 32

// Architectural registers, r0 hardwired to zero
`define MIPS_REG_COUNT 32

`define MIPS_RESET_PC 32'h0000_0000 // First fetch address

`endif

//--- hdl/mips_pkg.sv
package mips_pkg;

    typedef enum logic [2:0] {
        STATE_FETCH  = 3'd0,
        STATE_DECODE = 3'd1,
        STATE_EXEC1  = 3'd2,
        STATE_EXEC2  = 3'd3, // LW writeback only
        STATE_HALT   = 3'd4
    } cpu_state_t;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_ADDIU = 6'h09,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_t;

    // Operation class chosen by the controller
    typedef enum logic [2:0] {
        ALUOP_ADD, ALUOP_SUB, ALUOP_FUNCT, ALUOP_AND, ALUOP_OR, ALUOP_XOR
    } alu_op_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_func_t;

    typedef enum logic [1:0] {PC_ALU, PC_ALUOUT, PC_JUMP_TARGET, PC_REG_A} pc_source_t;
    typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA} reg_dst_t;
    typedef enum logic [1:0] {WB_ALUOUT, WB_MDR, WB_PC} mem_to_reg_t;

    typedef enum logic [2:0] {
        SRCB_B, SRCB_FOUR, SRCB_SIGN_IMM, SRCB_BRANCH_OFFSET, SRCB_ZERO_IMM
    } alu_src_b_t;

endpackage

//--- hdl/alu.sv
`include "mips_config.svh"

module alu (
    input  mips_pkg::alu_func_t   func,
    input  logic [`MIPS_XLEN-1:0] a,
    input  logic [`MIPS_XLEN-1:0] b,
    output logic [`MIPS_XLEN-1:0] result,
    output logic                  zero
);
    import mips_pkg::*;

    localparam int SHAMT_W = $clog2(`MIPS_XLEN);

    logic [SHAMT_W-1:0] shamt;

    assign shamt = a[SHAMT_W-1:0]; // Variable shifts take the amount from rs

    always_comb begin
        case (func)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLT:  result = {{(`MIPS_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(`MIPS_XLEN-1){1'b0}}, a < b};
            ALU_SLL:  result = b << shamt;
            ALU_SRL:  result = b >> shamt;
            ALU_SRA:  result = $signed(b) >>> shamt;
            default:  result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- hdl/register_file.sv
`include "mips_config.svh"

module register_file (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [$clog2(`MIPS_REG_COUNT)-1:0] read_addr_a,
    input  logic [$clog2(`MIPS_REG_COUNT)-1:0] read_addr_b,
    input  logic                               write_enable,
    input  logic [$clog2(`MIPS_REG_COUNT)-1:0] write_addr,
    input  logic [`MIPS_XLEN-1:0]              write_data,
    output logic [`MIPS_XLEN-1:0]              read_data_a,
    output logic [`MIPS_XLEN-1:0]              read_data_b
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_addr != '0) begin
            regs[write_addr] <= write_data;
        end
    end

    // r0 reads zero
    assign read_data_a = (read_addr_a == '0) ? '0 : regs[read_addr_a];
    assign read_data_b = (read_addr_b == '0) ? '0 : regs[read_addr_b];

endmodule

//--- hdl/controller.sv
module controller (
    input  mips_pkg::opcode_t    opcode,
    input  mips_pkg::funct_t     funct,
    input  mips_pkg::cpu_state_t state,
    output mips_pkg::reg_dst_t   reg_dst,
    output logic                 reg_write,
    output logic                 i_or_d,
    output logic                 ir_write,
    output logic                 pc_write,
    output mips_pkg::pc_source_t pc_source,
    output logic                 pc_write_cond,
    output logic                 jump,
    output logic                 three_cycle,
    output logic                 mem_read,
    output logic                 mem_write,
    output mips_pkg::mem_to_reg_t mem_to_reg,
    output mips_pkg::alu_op_t    alu_op,
    output logic                 alu_src_a,
    output mips_pkg::alu_src_b_t alu_src_b,
    output logic                 illegal
);
    import mips_pkg::*;

    always_comb begin
        reg_dst       = DST_RT;
        reg_write     = 1'b0;
        i_or_d        = 1'b0;
        ir_write      = 1'b0;
        pc_write      = 1'b0;
        pc_source     = PC_ALU;
        pc_write_cond = 1'b0;
        jump          = 1'b0;
        three_cycle   = 1'b0;
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        mem_to_reg    = WB_ALUOUT;
        alu_op        = ALUOP_ADD;
        alu_src_a     = 1'b0;
        alu_src_b     = SRCB_B;
        illegal       = 1'b0;

        case (state)
            STATE_FETCH: begin
                mem_read  = 1'b1;
                ir_write  = 1'b1;
                pc_write  = 1'b1;
                alu_src_b = SRCB_FOUR; // PC + 4
            end
            STATE_DECODE: begin
                alu_src_b = SRCB_BRANCH_OFFSET; // Branch target into ALU result reg
            end
            STATE_EXEC1: begin
                three_cycle = 1'b1;
                case (opcode)
                    OP_RTYPE: begin
                        case (funct)
                            FN_SLLV, FN_SRLV, FN_SRAV, FN_ADDU, FN_SUBU,
                            FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU: begin
                                reg_dst   = DST_RD;
                                reg_write = 1'b1;
                                alu_op    = ALUOP_FUNCT;
                                alu_src_a = 1'b1;
                            end
                            FN_JR: begin
                                pc_source = PC_REG_A;
                                jump      = 1'b1;
                            end
                            FN_JALR: begin
                                pc_source  = PC_REG_A;
                                jump       = 1'b1;
                                reg_dst    = DST_RD;
                                reg_write  = 1'b1;
                                mem_to_reg = WB_PC; // PC already holds PC + 4
                            end
                            default: illegal = 1'b1;
                        endcase
                    end
                    OP_J: begin
                        pc_source = PC_JUMP_TARGET;
                        jump      = 1'b1;
                    end
                    OP_JAL: begin
                        pc_source  = PC_JUMP_TARGET;
                        jump       = 1'b1;
                        reg_dst    = DST_RA;
                        reg_write  = 1'b1;
                        mem_to_reg = WB_PC;
                    end
                    OP_BEQ: begin
                        alu_op        = ALUOP_SUB; // Zero flag on equal
                        alu_src_a     = 1'b1;
                        pc_source     = PC_ALUOUT;
                        pc_write_cond = 1'b1;
                    end
                    OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI: begin
                        reg_write = 1'b1;
                        alu_src_a = 1'b1;
                        alu_src_b = (opcode == OP_ADDIU) ? SRCB_SIGN_IMM : SRCB_ZERO_IMM;
                        case (opcode)
                            OP_ANDI: alu_op = ALUOP_AND;
                            OP_ORI:  alu_op = ALUOP_OR;
                            OP_XORI: alu_op = ALUOP_XOR;
                            default: alu_op = ALUOP_ADD;
                        endcase
                    end
                    OP_LW: begin
                        three_cycle = 1'b0; // Writeback in exec2
                        i_or_d      = 1'b1;
                        mem_read    = 1'b1;
                        alu_src_a   = 1'b1;
                        alu_src_b   = SRCB_SIGN_IMM;
                    end
                    OP_SW: begin
                        i_or_d    = 1'b1;
                        mem_write = 1'b1;
                        alu_src_a = 1'b1;
                        alu_src_b = SRCB_SIGN_IMM;
                    end
                    default: illegal = 1'b1;
                endcase
            end
            STATE_EXEC2: begin
                if (opcode == OP_LW) begin
                    reg_write  = 1'b1;
                    mem_to_reg = WB_MDR;
                end
            end
            default: ; // Halt keeps every strobe low
        endcase
    end

endmodule

//--- hdl/alu_control.sv
module alu_control (
    input  mips_pkg::alu_op_t   alu_op,
    input  mips_pkg::funct_t    funct,
    output mips_pkg::alu_func_t alu_func
);
    import mips_pkg::*;

    always_comb begin
        case (alu_op)
            ALUOP_ADD: alu_func = ALU_ADD;
            ALUOP_SUB: alu_func = ALU_SUB;
            ALUOP_AND: alu_func = ALU_AND;
            ALUOP_OR:  alu_func = ALU_OR;
            ALUOP_XOR: alu_func = ALU_XOR;
            ALUOP_FUNCT: begin
                case (funct)
                    FN_SLLV: alu_func = ALU_SLL; // Amount from rs
                    FN_SRLV: alu_func = ALU_SRL;
                    FN_SRAV: alu_func = ALU_SRA;
                    FN_ADDU: alu_func = ALU_ADD;
                    FN_SUBU: alu_func = ALU_SUB;
                    FN_AND:  alu_func = ALU_AND;
                    FN_OR:   alu_func = ALU_OR;
                    FN_XOR:  alu_func = ALU_XOR;
                    FN_SLT:  alu_func = ALU_SLT;
                    FN_SLTU: alu_func = ALU_SLTU;
                    default: alu_func = ALU_ADD;
                endcase
            end
            default: alu_func = ALU_ADD;
        endcase
    end

endmodule

//--- hdl/datapath.sv
`include "mips_config.svh"

module datapath (
    input  logic                  clk,
    input  logic                  reset,
    input  mips_pkg::reg_dst_t    reg_dst,
    input  logic                  reg_write,
    input  logic                  i_or_d,
    input  logic                  ir_write,
    input  logic                  pc_write,
    input  mips_pkg::pc_source_t  pc_source,
    input  logic                  pc_write_cond,
    input  logic                  jump,
    input  logic                  three_cycle,
    input  logic                  mem_read_req,
    input  logic                  mem_write_req,
    input  mips_pkg::mem_to_reg_t mem_to_reg,
    input  logic                  alu_src_a,
    input  mips_pkg::alu_src_b_t  alu_src_b,
    input  logic                  illegal,
    input  mips_pkg::alu_func_t   alu_func,
    output mips_pkg::opcode_t     opcode,
    output mips_pkg::funct_t      funct,
    output mips_pkg::cpu_state_t  state,
    output logic [`MIPS_XLEN-1:0] mem_addr,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic [`MIPS_XLEN-1:0] mem_wdata,
    input  logic [`MIPS_XLEN-1:0] mem_rdata,
    output logic                  trap
);
    import mips_pkg::*;

    cpu_state_t            next_state;
    logic [`MIPS_XLEN-1:0] pc, pc_next, ir, a_reg, b_reg, alu_out, mdr;
    logic [`MIPS_XLEN-1:0] sign_imm, zero_imm, jump_target;
    logic [`MIPS_XLEN-1:0] alu_a, alu_b, alu_result, write_data;
    logic [`MIPS_XLEN-1:0] read_data_a, read_data_b;
    logic [4:0]            write_addr;
    logic                  zero, pc_en;

    assign opcode      = opcode_t'(ir[31:26]);
    assign funct       = funct_t'(ir[5:0]);
    assign sign_imm    = {{(`MIPS_XLEN-16){ir[15]}}, ir[15:0]};
    assign zero_imm    = {{(`MIPS_XLEN-16){1'b0}}, ir[15:0]};
    assign jump_target = {pc[`MIPS_XLEN-1 -: 4], ir[25:0], 2'b00}; // Upper bits of PC + 4

    always_comb begin
        alu_a = alu_src_a ? a_reg : pc;
        case (alu_src_b)
            SRCB_FOUR:          alu_b = `MIPS_XLEN'd4;
            SRCB_SIGN_IMM:      alu_b = sign_imm;
            SRCB_BRANCH_OFFSET: alu_b = sign_imm << 2;
            SRCB_ZERO_IMM:      alu_b = zero_imm;
            default:            alu_b = b_reg;
        endcase
        case (reg_dst)
            DST_RD:  write_addr = ir[15:11];
            DST_RA:  write_addr = 5'd31; // Link register
            default: write_addr = ir[20:16];
        endcase
        case (mem_to_reg)
            WB_MDR:  write_data = mdr;
            WB_PC:   write_data = pc;
            default: write_data = alu_result;
        endcase
        case (pc_source)
            PC_ALUOUT:      pc_next = alu_out;
            PC_JUMP_TARGET: pc_next = jump_target;
            PC_REG_A:       pc_next = a_reg;
            default:        pc_next = alu_result;
        endcase
    end

    assign pc_en = pc_write | jump | (pc_write_cond & zero);

    always_comb begin
        case (state)
            STATE_FETCH:  next_state = STATE_DECODE;
            STATE_DECODE: next_state = STATE_EXEC1;
            STATE_EXEC1:  next_state = three_cycle ? STATE_FETCH : STATE_EXEC2;
            STATE_EXEC2:  next_state = STATE_FETCH;
            default:      next_state = STATE_HALT;
        endcase
        if (illegal) begin
            next_state = STATE_HALT;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= STATE_FETCH;
            pc    <= `MIPS_RESET_PC;
        end else begin
            state <= next_state;
            if (pc_en) begin
                pc <= pc_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ir_write) begin
            ir <= mem_rdata;
        end
        if (state == STATE_DECODE) begin
            a_reg <= read_data_a;
            b_reg <= read_data_b;
        end
        alu_out <= alu_result; // Branch target survives into exec1
        mdr     <= mem_rdata;
    end

    assign mem_addr  = i_or_d ? alu_result : pc;
    assign mem_read  = mem_read_req & (state != STATE_HALT);
    assign mem_write = mem_write_req & (state != STATE_HALT);
    assign mem_wdata = b_reg;
    assign trap      = (state == STATE_HALT);

    register_file i_register_file (
        .clk          (clk),
        .reset        (reset),
        .read_addr_a  (ir[25:21]),
        .read_addr_b  (ir[20:16]),
        .write_enable (reg_write),
        .write_addr   (write_addr),
        .write_data   (write_data),
        .read_data_a  (read_data_a),
        .read_data_b  (read_data_b)
    );

    alu i_alu (
        .func   (alu_func),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .zero   (zero)
    );

endmodule

//--- hdl/mips_core.sv
`include "mips_config.svh"

module mips_core (
    input  logic                  clk,
    input  logic                  reset,
    output logic [`MIPS_XLEN-1:0] mem_addr,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic [`MIPS_XLEN-1:0] mem_wdata,
    input  logic [`MIPS_XLEN-1:0] mem_rdata,
    output logic                  trap
);
    import mips_pkg::*;

    opcode_t     opcode;
    funct_t      funct;
    cpu_state_t  state;
    reg_dst_t    reg_dst;
    pc_source_t  pc_source;
    mem_to_reg_t mem_to_reg;
    alu_op_t     alu_op;
    alu_src_b_t  alu_src_b;
    alu_func_t   alu_func;
    logic        reg_write, i_or_d, ir_write, pc_write, pc_write_cond, jump;
    logic        three_cycle, mem_read_req, mem_write_req, alu_src_a, illegal;

    controller i_controller (
        .opcode        (opcode),
        .funct         (funct),
        .state         (state),
        .reg_dst       (reg_dst),
        .reg_write     (reg_write),
        .i_or_d        (i_or_d),
        .ir_write      (ir_write),
        .pc_write      (pc_write),
        .pc_source     (pc_source),
        .pc_write_cond (pc_write_cond),
        .jump          (jump),
        .three_cycle   (three_cycle),
        .mem_read      (mem_read_req),
        .mem_write     (mem_write_req),
        .mem_to_reg    (mem_to_reg),
        .alu_op        (alu_op),
        .alu_src_a     (alu_src_a),
        .alu_src_b     (alu_src_b),
        .illegal       (illegal)
    );

    alu_control i_alu_control (
        .alu_op   (alu_op),
        .funct    (funct),
        .alu_func (alu_func)
    );

    datapath i_datapath (
        .clk           (clk),
        .reset         (reset),
        .reg_dst       (reg_dst),
        .reg_write     (reg_write),
        .i_or_d        (i_or_d),
        .ir_write      (ir_write),
        .pc_write      (pc_write),
        .pc_source     (pc_source),
        .pc_write_cond (pc_write_cond),
        .jump          (jump),
        .three_cycle   (three_cycle),
        .mem_read_req  (mem_read_req),
        .mem_write_req (mem_write_req),
        .mem_to_reg    (mem_to_reg),
        .alu_src_a     (alu_src_a),
        .alu_src_b     (alu_src_b),
        .illegal       (illegal),
        .alu_func      (alu_func),
        .opcode        (opcode),
        .funct         (funct),
        .state         (state),
        .mem_addr      (mem_addr),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_wdata     (mem_wdata),
        .mem_rdata     (mem_rdata),
        .trap          (trap)
    );

endmodule

//--- tests/mips_core_sva.sv
module mips_core_sva (
    input logic        clk,
    input logic        reset,
    input logic        mem_read,
    input logic        mem_write,
    input logic [31:0] mem_addr,
    input logic        trap
);
    timeunit 1ns;
    timeprecision 1ps;

    int assert_failures = 0; // Seen by the testbench

    a_strobes_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(mem_read && mem_write))
    else begin
        assert_failures++;
        $error("mem_read and mem_write high in the same cycle");
    end

    a_word_aligned: assert property (
        @(posedge clk) disable iff (reset) (mem_read || mem_write) |-> mem_addr[1:0] == 2'b00)
    else begin
        assert_failures++;
        $error("Unaligned memory address %h", mem_addr);
    end

    // Halt is final until reset
    a_trap_sticky: assert property (
        @(posedge clk) disable iff (reset) trap |=> (trap && !mem_write))
    else begin
        assert_failures++;
        $error("trap dropped or a store followed it");
    end

endmodule

bind mips_core mips_core_sva i_mips_core_sva (
    .clk       (clk),
    .reset     (reset),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .trap      (trap)
);

//--- tests/mips_core_tb.sv
module mips_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic [31:0] mem_addr;
    logic        mem_read;
    logic        mem_write;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic        trap;

    logic [31:0]  mem [256];
    logic [127:0] exp_name [256];
    logic [31:0]  exp_addr [256];
    logic [31:0]  exp_data [256];
    int           num_words = 0;
    int           num_stores = 0;
    int           store_count = 0;
    int           cycles = 0;
    int           limit;

    mips_core i_mips_core (
        .clk       (clk),
        .reset     (reset),
        .mem_addr  (mem_addr),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .trap      (trap)
    );

    // 1 KiB, word addressed; an idle bus returns an illegal opcode
    assign mem_rdata = mem_read ? mem[mem_addr[9:2]] : 32'hffff_ffff;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input logic [127:0] name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("ERR %0s %s: expected %h, actual %h",
                                        name, what, expected, actual));
        end
    endtask

    task automatic load_tests();
        int            fd;
        int            code;
        int            i;
        logic [127:0]  tag;
        logic [127:0]  name;
        logic [1023:0] rest;
        logic [31:0]   word;
        logic [31:0]   addr;
        logic [31:0]   data;
        for (i = 0; i < 256; i++) begin
            mem[i[7:0]] <= {6'h3f, 18'h0, i[7:0]}; // Illegal opcode tagged with its index
        end
        fd = $fopen("tests/mips_core_tests.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Cannot open tests/mips_core_tests.txt");
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "P") begin
                    code = $fscanf(fd, "%h", word);
                    if (code != 1) begin
                        stop_with_failure("Malformed program line in tests/mips_core_tests.txt");
                    end else begin
                        mem[num_words[7:0]] <= word;
                        num_words = num_words + 1;
                    end
                end else if (tag == "S") begin
                    code = $fscanf(fd, "%s %h %h", name, addr, data);
                    if (code != 3) begin
                        stop_with_failure("Malformed store line in tests/mips_core_tests.txt");
                    end else begin
                        exp_name[num_stores[7:0]] = name;
                        exp_addr[num_stores[7:0]] = addr;
                        exp_data[num_stores[7:0]] = data;
                        num_stores = num_stores + 1;
                    end
                end else if (tag == "#") begin
                    code = $fgets(rest, fd); // Rest of a comment line
                end else begin
                    stop_with_failure("Unknown line type in tests/mips_core_tests.txt");
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        forever #10 clk = ~clk;
    end

    // Store checker and memory update
    always @(posedge clk) begin
        if (!reset && mem_write) begin
            if (store_count >= num_stores) begin
                stop_with_failure($sformatf("Unexpected store of %h to address %h",
                                            mem_wdata, mem_addr));
            end else begin
                check_value(exp_name[store_count[7:0]], "address",
                            exp_addr[store_count[7:0]], mem_addr);
                check_value(exp_name[store_count[7:0]], "data",
                            exp_data[store_count[7:0]], mem_wdata);
                store_count = store_count + 1;
            end
            mem[mem_addr[9:2]] <= mem_wdata;
        end
    end

    initial begin
        load_tests();
        limit = 4 * num_words + 20; // Branches only go forward
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        while (trap !== 1'b1) begin
            @(negedge clk);
            cycles = cycles + 1;
            if (i_mips_core.i_mips_core_sva.assert_failures != 0) begin
                stop_with_failure("A memory port or trap assertion failed");
            end else if (cycles > limit) begin
                stop_with_failure($sformatf("Timeout, no trap after %0d cycles", limit));
            end
        end
        repeat (2) @(negedge clk); // Nothing may follow the trap
        if (store_count < num_stores) begin
            stop_with_failure($sformatf("Trap raised with %0d of %0d expected stores missing",
                                        num_stores - store_count, num_stores));
        end else if (i_mips_core.i_mips_core_sva.assert_failures != 0) begin
            stop_with_failure("A memory port or trap assertion failed");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

//--- tests/mips_core_tests.txt
# P <word>  instruction word, loaded from address 0 upward
# S <name> <addr> <data>  next expected store, in program order
P 2401fffb # addiu r1, r0, -5
P 34028003 # ori r2, r0, 0x8003
P 3023ff00 # andi r3, r1, 0xff00
P 38248000 # xori r4, r1, 0x8000
P 240d0004 # addiu r13, r0, 4
P ac010200 # sw r1, 0x200(r0)
S addiu_sext 00000200 fffffffb
P ac020204 # sw r2, 0x204(r0)
S ori_zext 00000204 00008003
P ac030208 # sw r3, 0x208(r0)
S andi_zext 00000208 0000ff00
P ac04020c # sw r4, 0x20c(r0)
S xori_zext 0000020c ffff7ffb
P 00222821 # addu r5, r1, r2
P 00413023 # subu r6, r2, r1
P 00223824 # and r7, r1, r2
P 00224025 # or r8, r1, r2
P 00224826 # xor r9, r1, r2
P 0022502a # slt r10, r1, r2
P 0022582b # sltu r11, r1, r2
P 01a26004 # sllv r12, r2, r13
P 01a17006 # srlv r14, r1, r13
P 01a17807 # srav r15, r1, r13
P ac050210 # sw r5, 0x210(r0)
S addu 00000210 00007ffe
P ac060214 # sw r6, 0x214(r0)
S subu 00000214 00008008
P ac070218 # sw r7, 0x218(r0)
S and 00000218 00008003
P ac08021c # sw r8, 0x21c(r0)
S or 0000021c fffffffb
P ac090220 # sw r9, 0x220(r0)
S xor 00000220 ffff7ff8
P ac0a0224 # sw r10, 0x224(r0)
S slt 00000224 00000001
P ac0b0228 # sw r11, 0x228(r0)
S sltu 00000228 00000000
P ac0c022c # sw r12, 0x22c(r0)
S sllv 0000022c 00080030
P ac0e0230 # sw r14, 0x230(r0)
S srlv 00000230 0fffffff
P ac0f0234 # sw r15, 0x234(r0)
S srav 00000234 ffffffff
P 8c100204 # lw r16, 0x204(r0)
P ac100238 # sw r16, 0x238(r0)
S lw_load 00000238 00008003
P 24000055 # addiu r0, r0, 0x55
P ac00023c # sw r0, 0x23c(r0)
S r0_zero 0000023c 00000000
P 10220001 # beq r1, r2, +1 not taken
P ac010240 # sw r1, 0x240(r0)
S beq_not_taken 00000240 fffffffb
P 10630001 # beq r3, r3, +1 taken
P ac020244 # sw r2, 0x244(r0) skipped
P ac030244 # sw r3, 0x244(r0)
S beq_taken 00000244 0000ff00
P 08000028 # j 0xa0
P ac020248 # sw r2, 0x248(r0) skipped
P ac040248 # sw r4, 0x248(r0)
S j_target 00000248 ffff7ffb
P 0c00002b # jal 0xac
P ac02024c # sw r2, 0x24c(r0) skipped
P ac1f024c # sw r31, 0x24c(r0)
S jal_link 0000024c 000000a8
P 241200bc # addiu r18, r0, 0xbc
P 02400008 # jr r18
P ac020250 # sw r2, 0x250(r0) skipped
P ac120250 # sw r18, 0x250(r0)
S jr_target 00000250 000000bc
P 241300cc # addiu r19, r0, 0xcc
P 0260a009 # jalr r20, r19
P ac020254 # sw r2, 0x254(r0) skipped
P ac140254 # sw r20, 0x254(r0)
S jalr_link 00000254 000000c8
P fc000000 # unsupported opcode, trap

//--- filelist.f
+incdir+hdl
hdl/mips_pkg.sv
hdl/alu.sv
hdl/register_file.sv
hdl/controller.sv
hdl/alu_control.sv
hdl/datapath.sv
hdl/mips_core.sv
tests/mips_core_sva.sv
tests/mips_core_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mips_core_tb -f filelist.f

output=$(./obj_dir/Vmips_core_tb 2>&1 || true)
echo "$output"

if echo "$output" | grep -qxF '** PASS **'; then
    exit 0
fi
exit 1
